// File: logic/p2r_pkg.sv
// ----------------------------------------------------------------------
// power2round shared definitions
// coefficient and split widths, vector types, controller state type
// ----------------------------------------------------------------------

package p2r_pkg;

    // ------------------------------------------------------------------
    // widths
    // ------------------------------------------------------------------
    // coefficient t, always below q = 8380417
    localparam int COEFF_W = 23;

    // dropped low bits, d in the spec
    localparam int D_BITS = 13;

    // high part keeps the remaining bits
    localparam int T1_W = COEFF_W - D_BITS;

    // ------------------------------------------------------------------
    // types
    // ------------------------------------------------------------------
    typedef logic [COEFF_W-1:0] coeff_t;

    typedef logic [T1_W-1:0] t1_t;

    // 4096 - t0, always in 0..8191
    typedef logic [D_BITS-1:0] t0_enc_t;

    // controller sequence, one pass per host request
    typedef enum logic [1:0] {
        P2R_IDLE  = 2'd0,
        P2R_RUN   = 2'd1,
        P2R_FLUSH = 2'd2,
        P2R_ACK   = 2'd3
    } p2r_state_t;

endpackage

// File: logic/coeff_mem.sv
// ----------------------------------------------------------------------
// coefficient source memory
// host loaded, one registered read per cycle for the split datapath
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module coeff_mem #(
    parameter int NUM_COEFF = 64
) (
    input  logic                       clk,
    input  logic                       reset_n,
    input  logic                       load_en,
    input  logic [$clog2(NUM_COEFF)-1:0] load_addr,
    input  p2r_pkg::coeff_t            load_data,
    input  logic                       rd_en,
    input  logic [$clog2(NUM_COEFF)-1:0] rd_addr,
    output p2r_pkg::coeff_t            rd_data,
    output logic                       rd_valid
);

    localparam int ADDR_W = $clog2(NUM_COEFF);

    p2r_pkg::coeff_t mem [NUM_COEFF];

    // host write port
    always_ff @(posedge clk) begin
        if (load_en) begin
            mem[load_addr] <= load_data;
        end
    end

    // registered read data
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr[ADDR_W-1:0]];
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= rd_en;
        end
    end

endmodule

// File: logic/p2r_ctrl.sv
// ----------------------------------------------------------------------
// power2round controller
// sequences coefficient reads, counts pk write addresses, holds off
// reads under buffer back-pressure and runs the host start handshake
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module p2r_ctrl #(
    parameter int NUM_COEFF = 64
) (
    input  logic                         clk,
    input  logic                         reset_n,
    input  logic                         start_req,
    input  logic                         rd_valid,
    input  logic                         buf_stall,
    input  logic                         buf_empty,
    input  logic                         pk_wren,
    output logic                         start_ack,
    output logic                         rd_en,
    output logic [$clog2(NUM_COEFF)-1:0] rd_addr,
    output logic [$clog2(NUM_COEFF)-1:0] pk_addr
);

    localparam int ADDR_W = $clog2(NUM_COEFF);
    localparam logic [ADDR_W-1:0] LAST_ADDR = ADDR_W'(NUM_COEFF - 1);

    p2r_pkg::p2r_state_t state;
    p2r_pkg::p2r_state_t state_nxt;
    // reads issued whose rd_valid has not come back yet
    logic [1:0]          inflight;
    logic                pipe_empty;

    // reads only in RUN, and never against a filling sk buffer
    assign rd_en     = (state == p2r_pkg::P2R_RUN) && !buf_stall;
    assign start_ack = (state == p2r_pkg::P2R_ACK);

    // pk_wren doubles as the split stage valid
    assign pipe_empty = (inflight == '0) && !pk_wren;

    // ------------------------------------------------------------------
    // state machine
    // ------------------------------------------------------------------
    always_comb begin
        state_nxt = state;
        case (state)
            p2r_pkg::P2R_IDLE: begin
                if (start_req) begin
                    state_nxt = p2r_pkg::P2R_RUN;
                end
            end
            p2r_pkg::P2R_RUN: begin
                if (rd_en && (rd_addr == LAST_ADDR)) begin
                    state_nxt = p2r_pkg::P2R_FLUSH;
                end
            end
            p2r_pkg::P2R_FLUSH: begin
                if (pipe_empty && buf_empty) begin
                    state_nxt = p2r_pkg::P2R_ACK;
                end
            end
            p2r_pkg::P2R_ACK: begin
                if (!start_req) begin
                    state_nxt = p2r_pkg::P2R_IDLE;
                end
            end
        endcase
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state <= p2r_pkg::P2R_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // ------------------------------------------------------------------
    // counters
    // ------------------------------------------------------------------
    // read address, restarts from 0 on every run
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rd_addr <= '0;
        end else if (state == p2r_pkg::P2R_IDLE) begin
            rd_addr <= '0;
        end else if (rd_en) begin
            rd_addr <= rd_addr + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            inflight <= '0;
        end else begin
            case ({rd_en, rd_valid})
                2'b10:   inflight <= inflight + 1'b1;
                2'b01:   inflight <= inflight - 1'b1;
                default: inflight <= inflight;
            endcase
        end
    end

    // pk write address, one step per pk write
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            pk_addr <= '0;
        end else if (state == p2r_pkg::P2R_IDLE) begin
            pk_addr <= '0;
        end else if (pk_wren) begin
            pk_addr <= pk_addr + 1'b1;
        end
    end

endmodule

// File: logic/p2r_split.sv
// ----------------------------------------------------------------------
// power2round split stage
// t1 = (t + 4095) >> 13 and the encoded low part 4096 - t0,
// registered one cycle after each valid read
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module p2r_split (
    input  logic               clk,
    input  logic               reset_n,
    input  p2r_pkg::coeff_t    rd_data,
    input  logic               rd_valid,
    output p2r_pkg::t1_t       t1,
    output p2r_pkg::t0_enc_t   t0_enc,
    output logic               split_valid
);

    // rounding offset 2^(d-1) - 1
    localparam p2r_pkg::coeff_t ROUND_OFS = p2r_pkg::coeff_t'((1 << (p2r_pkg::D_BITS - 1)) - 1);
    localparam p2r_pkg::t0_enc_t HALF = p2r_pkg::t0_enc_t'(1 << (p2r_pkg::D_BITS - 1));

    p2r_pkg::coeff_t   rounded;
    p2r_pkg::t1_t      t1_nxt;
    p2r_pkg::t0_enc_t  t0_enc_nxt;

    // t < q keeps t + 4095 inside 23 bits, no carry out
    assign rounded = rd_data + ROUND_OFS;
    assign t1_nxt  = rounded[p2r_pkg::COEFF_W-1:p2r_pkg::D_BITS];

    // t1*2^13 vanishes mod 2^13, and 4096 - t0 lands in 0..8191,
    // so only the low bits of t matter
    assign t0_enc_nxt = HALF - rd_data[p2r_pkg::D_BITS-1:0];

    always_ff @(posedge clk) begin
        if (rd_valid) begin
            t1     <= t1_nxt;
            t0_enc <= t0_enc_nxt;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            split_valid <= 1'b0;
        end else begin
            split_valid <= rd_valid;
        end
    end

endmodule

// File: logic/sk_wr_buf.sv
// ----------------------------------------------------------------------
// secret-key write buffer
// four-entry FIFO of encoded t0, drained to the shared sk memory
// port under sk_grant, with the sk write address counter
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module sk_wr_buf #(
    parameter int NUM_COEFF = 64
) (
    input  logic                         clk,
    input  logic                         reset_n,
    input  logic                         start_req,
    input  logic                         split_valid,
    input  p2r_pkg::t0_enc_t             t0_enc,
    input  logic                         sk_grant,
    output logic                         sk_wren,
    output logic [$clog2(NUM_COEFF)-1:0] sk_addr,
    output p2r_pkg::t0_enc_t             sk_data,
    output logic                         buf_stall,
    output logic                         buf_empty
);

    localparam int ADDR_W = $clog2(NUM_COEFF);
    localparam int DEPTH  = 4;
    localparam int PTR_W  = $clog2(DEPTH);

    p2r_pkg::t0_enc_t  fifo [DEPTH];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [PTR_W:0]    count;
    logic              push;
    logic              pop;

    assign push = split_valid;
    assign pop  = sk_wren & sk_grant;

    // entry storage
    always_ff @(posedge clk) begin
        if (push) begin
            fifo[wr_ptr] <= t0_enc;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // sk address, restarts with every run
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            sk_addr <= '0;
        end else if (!start_req) begin
            sk_addr <= '0;
        end else if (pop) begin
            sk_addr <= sk_addr + ADDR_W'(1);
        end
    end

    assign sk_wren   = (count != '0);
    assign sk_data   = fifo[rd_ptr];
    assign buf_empty = (count == '0);

    // two held entries plus the two reads still in the pipe
    assign buf_stall = (count >= (PTR_W+1)'(2));

endmodule

// File: logic/p2r_top.sv
// ----------------------------------------------------------------------
// power2round subsystem top
// read, split, then pk write and buffered sk drain
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module p2r_top #(
    parameter int NUM_COEFF = 64
) (
    input  logic                         clk,
    input  logic                         reset_n,
    input  logic                         start_req,
    input  logic                         load_en,
    input  logic [$clog2(NUM_COEFF)-1:0] load_addr,
    input  p2r_pkg::coeff_t              load_data,
    input  logic                         sk_grant,
    output logic                         start_ack,
    output logic                         pk_wren,
    output logic [$clog2(NUM_COEFF)-1:0] pk_addr,
    output p2r_pkg::t1_t                 pk_data,
    output logic                         sk_wren,
    output logic [$clog2(NUM_COEFF)-1:0] sk_addr,
    output p2r_pkg::t0_enc_t             sk_data
);

    localparam int ADDR_W = $clog2(NUM_COEFF);

    logic              rd_en;
    logic [ADDR_W-1:0] rd_addr;
    p2r_pkg::coeff_t   rd_data;
    logic              rd_valid;
    p2r_pkg::t0_enc_t  t0_enc;
    logic              split_valid;
    logic              buf_stall;
    logic              buf_empty;

    // ------------------------------------------------------------------
    // read and control
    // ------------------------------------------------------------------
    coeff_mem #(
        .NUM_COEFF (NUM_COEFF)
    ) u_coeff_mem (
        .clk       (clk),
        .reset_n   (reset_n),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data),
        .rd_en     (rd_en),
        .rd_addr   (rd_addr),
        .rd_data   (rd_data),
        .rd_valid  (rd_valid)
    );

    p2r_ctrl #(
        .NUM_COEFF (NUM_COEFF)
    ) u_p2r_ctrl (
        .clk       (clk),
        .reset_n   (reset_n),
        .start_req (start_req),
        .rd_valid  (rd_valid),
        .buf_stall (buf_stall),
        .buf_empty (buf_empty),
        .pk_wren   (pk_wren),
        .start_ack (start_ack),
        .rd_en     (rd_en),
        .rd_addr   (rd_addr),
        .pk_addr   (pk_addr)
    );

    // ------------------------------------------------------------------
    // split and write paths
    // ------------------------------------------------------------------
    p2r_split u_p2r_split (
        .clk         (clk),
        .reset_n     (reset_n),
        .rd_data     (rd_data),
        .rd_valid    (rd_valid),
        .t1          (pk_data),
        .t0_enc      (t0_enc),
        .split_valid (split_valid)
    );

    // pk side has no back-pressure
    assign pk_wren = split_valid;

    sk_wr_buf #(
        .NUM_COEFF (NUM_COEFF)
    ) u_sk_wr_buf (
        .clk         (clk),
        .reset_n     (reset_n),
        .start_req   (start_req),
        .split_valid (split_valid),
        .t0_enc      (t0_enc),
        .sk_grant    (sk_grant),
        .sk_wren     (sk_wren),
        .sk_addr     (sk_addr),
        .sk_data     (sk_data),
        .buf_stall   (buf_stall),
        .buf_empty   (buf_empty)
    );

endmodule

// File: verification/p2r_tb.sv
// ----------------------------------------------------------------------
// power2round testbench
// loads three runs of coefficients, runs the start handshake and
// checks every pk and sk write against the split rule
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module p2r_tb;

    localparam int NUM_COEFF   = 16;
    localparam int NUM_RUNS    = 3;
    localparam int ADDR_W      = $clog2(NUM_COEFF);
    localparam int CLK_NS      = 40;
    localparam int DRIVE_NS    = 2;
    localparam int WATCHDOG_NS = NUM_RUNS * NUM_COEFF * 20 * CLK_NS;
    localparam int WAIT_CYCLES = NUM_COEFF * 20;

    logic                clk      = 1'b0;
    logic                sk_grant = 1'b0;
    logic                reset_n;
    logic                start_req;
    logic                load_en;
    logic [ADDR_W-1:0]   load_addr;
    p2r_pkg::coeff_t     load_data;
    logic                hold_grant;
    logic                start_ack;
    logic                pk_wren;
    logic [ADDR_W-1:0]   pk_addr;
    p2r_pkg::t1_t        pk_data;
    logic                sk_wren;
    logic [ADDR_W-1:0]   sk_addr;
    p2r_pkg::t0_enc_t    sk_data;

    p2r_pkg::coeff_t     patterns [0:NUM_RUNS*NUM_COEFF-1];

    // monitor state
    int   pk_cnt   = 0;
    int   sk_cnt   = 0;
    int   mon_run  = 0;
    logic req_prev = 1'b0;
    logic ack_prev = 1'b0;

    p2r_top #(
        .NUM_COEFF (NUM_COEFF)
    ) dut0 (
        .clk       (clk),
        .reset_n   (reset_n),
        .start_req (start_req),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data),
        .sk_grant  (sk_grant),
        .start_ack (start_ack),
        .pk_wren   (pk_wren),
        .pk_addr   (pk_addr),
        .pk_data   (pk_data),
        .sk_wren   (sk_wren),
        .sk_addr   (sk_addr),
        .sk_data   (sk_data)
    );

    always #(CLK_NS/2) clk = ~clk;

    // ------------------------------------------------------------------
    // reference rule and error handling
    // ------------------------------------------------------------------
    function automatic int high_part(input int t);
        return (t + 4095) / 8192;
    endfunction

    // encoded value is 4096 - t0, with t0 = t - t1*8192
    function automatic int encoded_low_part(input int t);
        int t0;
        t0 = t - high_part(t) * 8192;
        return 4096 - t0;
    endfunction

    task automatic abort_run();
        $display("FAIL: see errors above");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] expected);
        $display("[FAIL] %s got 0x%0h expected 0x%0h at %0t", name, got, expected, $time);
        abort_run();
    endtask

    // ------------------------------------------------------------------
    // stimulus helpers
    // ------------------------------------------------------------------
    task automatic load_coeffs(input int run);
        for (int i = 0; i < NUM_COEFF; i++) begin
            @(posedge clk);
            #(DRIVE_NS);
            load_en   = 1'b1;
            load_addr = ADDR_W'(i);
            load_data = patterns[run*NUM_COEFF + i];
        end
        @(posedge clk);
        #(DRIVE_NS);
        load_en = 1'b0;
    endtask

    task automatic wait_for_ack(input logic level);
        int n;
        n = 0;
        while (start_ack !== level && n < WAIT_CYCLES) begin
            @(negedge clk);
            n++;
        end
        assert (start_ack === level) else begin
            $display("start_ack did not go to %0b within %0d cycles", level, WAIT_CYCLES);
            abort_run();
        end
    endtask

    task automatic run_handshake();
        @(posedge clk);
        #(DRIVE_NS);
        start_req = 1'b1;
        wait_for_ack(1'b1);
        // keep the request up a little, ack has to hold
        repeat (2) @(negedge clk);
        @(posedge clk);
        #(DRIVE_NS);
        start_req = 1'b0;
        wait_for_ack(1'b0);
    endtask

    // random grant, held high for the full-rate run
    always @(posedge clk) begin
        #(DRIVE_NS);
        if (hold_grant) begin
            sk_grant = 1'b1;
        end else begin
            sk_grant = 1'($urandom % 2);
        end
    end

    // ------------------------------------------------------------------
    // output monitor, samples mid-cycle
    // ------------------------------------------------------------------
    always @(negedge clk) begin : monitor
        int               base;
        p2r_pkg::t1_t     exp_t1;
        p2r_pkg::t0_enc_t exp_enc;
        if (reset_n) begin
            if (start_req && !req_prev) begin
                pk_cnt  = 0;
                sk_cnt  = 0;
                mon_run = mon_run + 1;
            end
            base = (mon_run - 1) * NUM_COEFF;

            if (!start_req && !start_ack) begin
                assert (!pk_wren && !sk_wren) else begin
                    $display("write strobe active with no run requested at %0t", $time);
                    abort_run();
                end
            end

            // ack checks use the counts of earlier cycles
            if (start_ack && !ack_prev) begin
                assert (pk_cnt == NUM_COEFF && sk_cnt == NUM_COEFF) else begin
                    $display("start_ack rose after %0d pk and %0d sk writes", pk_cnt, sk_cnt);
                    abort_run();
                end
            end
            if (ack_prev && !start_ack) begin
                assert (!start_req) else begin
                    $display("start_ack fell while start_req was still high");
                    abort_run();
                end
            end

            if (mon_run == NUM_RUNS && pk_cnt > 0 && pk_cnt < NUM_COEFF) begin
                assert (pk_wren) else begin
                    $display("gap after pk write %0d in the full-rate run", pk_cnt);
                    abort_run();
                end
            end

            if (pk_wren) begin
                assert (pk_cnt < NUM_COEFF) else begin
                    $display("more than %0d pk writes in run %0d", NUM_COEFF, mon_run);
                    abort_run();
                end
                exp_t1 = p2r_pkg::t1_t'(high_part(int'(patterns[base + pk_cnt])));
                assert (pk_addr === ADDR_W'(pk_cnt))
                    else report_mismatch("pk_addr", 32'(pk_addr), 32'(pk_cnt));
                assert (pk_data === exp_t1)
                    else report_mismatch("pk_data", 32'(pk_data), 32'(exp_t1));
                pk_cnt++;
            end

            if (sk_wren && sk_grant) begin
                assert (sk_cnt < NUM_COEFF) else begin
                    $display("more than %0d sk writes in run %0d", NUM_COEFF, mon_run);
                    abort_run();
                end
                exp_enc = p2r_pkg::t0_enc_t'(encoded_low_part(int'(patterns[base + sk_cnt])));
                assert (sk_addr === ADDR_W'(sk_cnt))
                    else report_mismatch("sk_addr", 32'(sk_addr), 32'(sk_cnt));
                assert (sk_data === exp_enc)
                    else report_mismatch("sk_data", 32'(sk_data), 32'(exp_enc));
                sk_cnt++;
            end

            req_prev = start_req;
            ack_prev = start_ack;
        end
    end

    // ------------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------------
    initial begin
        void'($urandom(32'h7d53));
        reset_n    = 1'b0;
        start_req  = 1'b0;
        load_en    = 1'b0;
        load_addr  = '0;
        load_data  = '0;
        hold_grant = 1'b0;
        $readmemh("verification/p2r_patterns.txt", patterns);

        repeat (3) @(posedge clk);
        #(DRIVE_NS);
        reset_n = 1'b1;

        // quiet outputs before any request
        repeat (4) begin
            @(negedge clk);
            assert (!start_ack && !pk_wren && !sk_wren) else begin
                $display("outputs active after reset with no request");
                abort_run();
            end
        end

        for (int r = 0; r < NUM_RUNS; r++) begin
            load_coeffs(r);
            hold_grant = (r == NUM_RUNS - 1);
            run_handshake();
        end

        $display("PASS: all tests");
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, the runs did not complete", WATCHDOG_NS);
        abort_run();
    end

endmodule

// File: verification/p2r_patterns.txt
// one 23-bit coefficient t per line in hex, all below q = 7fe001
// 48 words, run r holds words r*16 .. r*16+15
// run 1, boundary values first
000000
000fff
001000
001fff
002000
7fe000
000001
002fff
003000
400000
3fffff
7fdfff
0a1b2c
123456
5ace11
6f0f0f
// run 2, mixed values under random grant
2b7e15
162812
0f1c3a
7c0001
04d2e1
38f4a0
55aa55
1e2400
66dead
00beef
3c0ffe
71c9b3
0abcde
4f1200
29a7f3
7fd001
// run 3, full rate with the grant held high
001001
00f000
7f0000
333333
1fffff
200000
0c0de5
6a5f00
000800
001800
1e0fff
47c1d2
5b6e08
7fe000
000000
3fe001

// File: verilog.f
logic/p2r_pkg.sv
logic/coeff_mem.sv
logic/p2r_ctrl.sv
logic/p2r_split.sv
logic/sk_wr_buf.sv
logic/p2r_top.sv
verification/p2r_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# compile and run the power2round testbench with Verilator
cd "$(dirname "$0")" || exit 1
LOG=sim.log
FAIL_MSG="FAIL: see errors above"

verilator --binary --timing -Wno-fatal -f verilog.f --top-module p2r_tb -o p2r_sim \
    > "$LOG" 2>&1 \
    && ./obj_dir/p2r_sim >> "$LOG" 2>&1 \
    || echo "$FAIL_MSG" >> "$LOG"

cat "$LOG"
grep -q "$FAIL_MSG" "$LOG" && exit 1 || exit 0
